//--- apu_pulse.f
logic/apu_pkg.sv
logic/apu_frame_sequencer.sv
logic/apu_pulse_regs.sv
logic/apu_sweep_timer_unit.sv
logic/apu_pulse_envelope.sv
logic/apu_pulse_sequencer.sv
logic/apu_pulse_channel.sv
dv/apu_pulse_tb.sv

//--- dv/apu_pulse_tb.sv
/* Runs with quarter_frame_cycles = 64 and the default ones' complement negate.
   Step lengths are measured between changes of sample, in cpu_clk cycles. */
`default_nettype none

module apu_pulse_tb;

	import apu_pkg::*;

	localparam int qf = 64;
	localparam int hf = 2 * qf;
	localparam int ones = 1;
	localparam int edge_limit = 20000;
	// Worst case length of each test in cycles
	localparam int t1 = 6 * 8 * 201;
	localparam int t2 = 700 + 2 * 2000;
	localparam int t3 = 4 * (2 * hf + 5 * 4 * 2 * 286);
	localparam int t4 = 9 * hf + 300;
	localparam int t5 = 17 * qf + 24 * qf + 100;
	localparam int watchdog_cycles = 16 + t1 + t2 + t3 + t4 + t5 + 2000;

	logic       cpu_clk = 1'b0;
	logic       reset = 1'b1;
	logic       reg_write = 1'b0;
	logic [1:0] reg_addr = 2'd0;
	reg_data_u  reg_data;
	logic [3:0] sample;
	logic       active;

	int unsigned cycle = 0;
	int unsigned release_cycle = 0;
	int unsigned edge_cycle = 0;
	int unsigned edge_count = 0;
	logic [3:0]  last_sample = 4'd0;

	apu_pulse_channel #(
		.quarter_frame_cycles(qf)
	) uut (
		.cpu_clk  (cpu_clk),
		.reset    (reset),
		.reg_write(reg_write),
		.reg_addr (reg_addr),
		.reg_data (reg_data),
		.sample   (sample),
		.active   (active)
	);

	initial begin
		forever #10 cpu_clk = ~cpu_clk;
	end

	always @(posedge cpu_clk)
		cycle <= cycle + 1;

	// Records every change of sample, seen at the falling edge
	always @(negedge cpu_clk) begin
		if (sample !== last_sample) begin
			last_sample <= sample;
			edge_cycle  <= cycle;
			edge_count  <= edge_count + 1;
		end
	end

	initial begin
		repeat (watchdog_cycles) @(posedge cpu_clk);
		$display("Watchdog expired before the tests finished");
		$display("Testbench failed");
		$fatal(1);
	end

	//============================================================
	// Reference model
	//============================================================
	function automatic int step_cycles(input int period);
		return 2 * (period + 1);
	endfunction

	function automatic int sweep_target(input int period, input bit neg, input int shift);
		if (neg)
			return period - (period >> shift) - ones;
		return period + (period >> shift);
	endfunction

	function automatic bit mute_state(input int period, input bit neg, input int shift);
		if (period < 8)
			return 1'b1;
		return !neg && (sweep_target(period, 1'b0, shift) > 2047);
	endfunction

	function automatic bit duty_level(input int duty, input int step);
		return duty_table[duty][7 - step];
	endfunction

	// Length in steps of a high or low run of the pattern
	function automatic int run_steps(input int duty, input bit high);
		int n;
		n = 0;
		for (int s = 0; s < 8; s++)
			if (duty_level(duty, s) == high)
				n++;
		return n;
	endfunction

	//============================================================
	// Tasks
	//============================================================
	task automatic report_mismatch(input string name, input int exp, input int act);
		$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic write_reg(input logic [1:0] addr, input logic [7:0] data);
		@(posedge cpu_clk);
		#2;
		reg_write    = 1'b1;
		reg_addr     = addr;
		reg_data.raw = data;
		@(posedge cpu_clk);
		#2;
		reg_write = 1'b0;
	endtask

	task automatic wait_sample_edge(output int unsigned at, output logic [3:0] level);
		int unsigned start;
		int waited;
		start = edge_count;
		waited = 0;
		while (edge_count == start) begin
			@(posedge cpu_clk);
			waited++;
			if (waited > edge_limit)
				report_error("Sample stopped changing while a step edge was expected");
		end
		at = edge_cycle;
		level = last_sample;
	endtask

	// Skips two edges, then checks two runs against the reference step length
	task automatic check_step_runs(input string name, input int period, input int duty,
			input logic [3:0] vol);
		int unsigned t[3];
		logic [3:0]  v[3];
		int exp;
		wait_sample_edge(t[0], v[0]);
		wait_sample_edge(t[0], v[0]);
		for (int i = 0; i < 3; i++)
			wait_sample_edge(t[i], v[i]);
		for (int i = 0; i < 2; i++) begin
			exp = run_steps(duty, v[i] != 4'd0) * step_cycles(period);
			assert (int'(t[i + 1] - t[i]) == exp)
				else report_mismatch(name, exp, int'(t[i + 1] - t[i]));
			if (v[i] != 4'd0) begin
				assert (v[i] == vol) else report_mismatch(name, vol, v[i]);
			end
		end
	endtask

	task automatic hold_silent(input string name, input int n, input bit exp_active);
		repeat (n) begin
			@(negedge cpu_clk);
			assert (sample == 4'd0) else report_mismatch(name, 0, sample);
			assert (active == exp_active) else report_mismatch(name, exp_active, active);
		end
	endtask

	// Half frames fall near multiples of hf after reset release
	task automatic align_mid_frame();
		do
			@(posedge cpu_clk);
		while (((cycle - release_cycle) % hf) != qf);
	endtask

	//============================================================
	// Stimulus
	//============================================================
	initial begin
		int p;
		int shift;
		int len;
		int waited;
		int seen;
		int exp;
		int unsigned start;
		bit neg;
		logic [3:0] vol;
		logic [3:0] lv;
		logic [4:0] idx;

		reg_data.raw = 8'h00;
		void'($urandom(32'hc7d1_cd66));
		repeat (16) @(posedge cpu_clk);
		#2;
		reset = 1'b0;
		release_cycle = cycle;

		// Constant volume, duty 2, halted length
		vol = 4'(1 + $urandom % 15);
		p = 8 + $urandom % 193;
		write_reg(2'd0, {2'b10, 1'b1, 1'b1, vol});
		write_reg(2'd1, 8'h00);
		write_reg(2'd2, 8'(p));
		write_reg(2'd3, {5'd1, 3'(p >> 8)});
		check_step_runs("const_volume", p, 2, vol);

		// Short period mutes
		p = $urandom % 8;
		write_reg(2'd2, 8'(p));
		write_reg(2'd3, {5'd1, 3'd0});
		repeat (4) @(posedge cpu_clk);
		hold_silent("mute_low_period", 300, 1'b1);

		// Add target above the top mutes, held past the low step 0
		p = 1400 + $urandom % 600;
		write_reg(2'd1, {1'b0, 3'd0, 1'b0, 3'd1});
		write_reg(2'd2, 8'(p));
		write_reg(2'd3, {5'd1, 3'(p >> 8)});
		repeat (4) @(posedge cpu_clk);
		hold_silent("mute_overflow", step_cycles(p) + 300, 1'b1);
		write_reg(2'd1, 8'h00);

		// Sweep, one applied half frame per round
		p = 64 + $urandom % 64;
		write_reg(2'd2, 8'(p));
		write_reg(2'd3, {5'd1, 3'(p >> 8)});
		check_step_runs("sweep_start", p, 2, vol);
		for (int r = 0; r < 3; r++) begin
			neg = r[0];
			shift = 1 + $urandom % 3;
			align_mid_frame();
			write_reg(2'd1, {1'b1, 3'd0, neg, 3'(shift)});
			repeat (hf) @(posedge cpu_clk);
			write_reg(2'd1, 8'h00);
			// A muted channel keeps its period
			p = mute_state(p, neg, shift) ? p : sweep_target(p, neg, shift);
			check_step_runs(neg ? "sweep_negate" : "sweep_add", p, 2, vol);
		end

		// Length counter
		idx = 5'(3 + 2 * ($urandom % 4));
		len = length_table[idx];
		write_reg(2'd0, {2'b10, 1'b0, 1'b1, vol});
		write_reg(2'd2, 8'd20);
		write_reg(2'd3, {idx, 3'd0});
		start = cycle;
		waited = 0;
		while (active) begin
			@(negedge cpu_clk);
			waited++;
			if (waited > (len + 2) * hf)
				report_error("Length counter never cleared active");
		end
		assert (int'(cycle - start) > (len - 1) * hf && int'(cycle - start) <= len * hf + 4)
			else report_mismatch("length_expiry", len * hf, int'(cycle - start));
		hold_silent("length_silent", 200, 1'b0);

		// Envelope, first let the decay level run down to 0
		write_reg(2'd0, {2'b11, 1'b0, 1'b1, 4'd0});
		write_reg(2'd2, 8'd8);
		write_reg(2'd3, {5'd1, 3'd0});
		repeat (17 * qf) @(posedge cpu_clk);
		write_reg(2'd3, {5'd1, 3'd0});
		write_reg(2'd0, {2'b11, 1'b1, 1'b0, 4'd0});
		lv = 4'd0;
		seen = 0;
		waited = 0;
		while (seen < 20) begin
			@(negedge cpu_clk);
			waited++;
			if (waited > 24 * qf)
				report_error("Envelope level stopped changing");
			if (sample != 4'd0 && sample != lv) begin
				// Level 0 never shows, so 1 is followed by 15
				exp = (seen == 0 || lv <= 4'd1) ? 15 : lv - 1;
				assert (sample == exp) else report_mismatch("envelope_decay", exp, sample);
				lv = sample;
				seen++;
			end
		end

		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/apu_frame_sequencer.sv
/* 4-step frame mode only, no frame interrupt.
   First quarter frame comes quarter_frame_cycles cycles after reset drops. */
`default_nettype none

module apu_frame_sequencer #(
	parameter int quarter_frame_cycles = 7457
) (
	input  wire logic cpu_clk,
	input  wire logic reset,
	output logic      quarter_frame,
	output logic      half_frame
);

	localparam int cnt_w = $clog2(quarter_frame_cycles);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(quarter_frame_cycles - 1);

	logic [cnt_w-1:0] cycle_cnt;
	logic             phase;
	logic             wrap;

	assign wrap = (cycle_cnt == cnt_last);

	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			cycle_cnt     <= '0;
			phase         <= 1'b0;
			quarter_frame <= 1'b0;
			half_frame    <= 1'b0;
		end else begin
			cycle_cnt     <= wrap ? '0 : cycle_cnt + 1'b1;
			quarter_frame <= wrap;
			// Every second quarter frame is also a half frame
			half_frame    <= wrap & phase;
			if (wrap)
				phase <= ~phase;
		end
	end

endmodule

`default_nettype wire

//--- logic/apu_pkg.sv
/* Register field layouts and lookup tables for one pulse channel.
   Field order in the structs follows the bit order of the NES register bytes. */
`default_nettype none

package apu_pkg;

	// Control register, address 0
	typedef struct packed {
		logic [1:0] duty;
		logic       halt_loop;
		logic       const_vol;
		logic [3:0] vol_period;
	} pulse_ctrl_t;

	// Sweep register, address 1
	typedef struct packed {
		logic       enable;
		logic [2:0] period;
		logic       negate;
		logic [2:0] shift;
	} sweep_ctrl_t;

	// Same write byte, read as control or sweep by address
	typedef union packed {
		pulse_ctrl_t ctrl;
		sweep_ctrl_t sweep;
		logic [7:0]  raw;
	} reg_data_u;

	typedef struct packed {
		pulse_ctrl_t ctrl;
		sweep_ctrl_t sweep;
		logic [10:0] timer;
	} pulse_regs_t;

	// Step 0 is the leftmost bit
	localparam logic [7:0] duty_table [4] = '{
		8'b0100_0000, 8'b0110_0000, 8'b0111_1000, 8'b1001_1111
	};

	localparam logic [7:0] length_table [32] = '{
		8'd10,  8'd254, 8'd20,  8'd2,  8'd40, 8'd4,  8'd80, 8'd6,
		8'd160, 8'd8,   8'd60,  8'd10, 8'd14, 8'd12, 8'd26, 8'd14,
		8'd12,  8'd16,  8'd24,  8'd18, 8'd48, 8'd20, 8'd96, 8'd22,
		8'd192, 8'd24,  8'd72,  8'd26, 8'd16, 8'd28, 8'd32, 8'd30
	};

	localparam logic [10:0] period_max = 11'h7FF;

endpackage

`default_nettype wire

//--- logic/apu_pulse_channel.sv
/* Single pulse channel, all blocks on cpu_clk with one-cycle enables.
   No mixer, no DAC. Sample is the raw 4-bit channel output. */
`default_nettype none

module apu_pulse_channel #(
	parameter int quarter_frame_cycles   = 7457,
	parameter bit negate_ones_complement = 1'b1
) (
	input  wire logic               cpu_clk,
	input  wire logic               reset,
	input  wire logic               reg_write,
	input  wire logic [1:0]         reg_addr,
	input  wire apu_pkg::reg_data_u reg_data,
	output logic [3:0]              sample,
	output logic                    active
);

	import apu_pkg::*;

	pulse_regs_t regs;
	logic        sweep_reload;
	logic        timer_reload;
	logic        channel_restart;
	logic [4:0]  length_index;
	logic        quarter_frame;
	logic        half_frame;
	logic        step_tick;
	logic        mute;
	logic [3:0]  volume;

	apu_frame_sequencer #(
		.quarter_frame_cycles(quarter_frame_cycles)
	) u_frame_seq (
		.cpu_clk      (cpu_clk),
		.reset        (reset),
		.quarter_frame(quarter_frame),
		.half_frame   (half_frame)
	);

	apu_pulse_regs u_regs (
		.cpu_clk        (cpu_clk),
		.reset          (reset),
		.reg_write      (reg_write),
		.reg_addr       (reg_addr),
		.reg_data       (reg_data),
		.regs           (regs),
		.sweep_reload   (sweep_reload),
		.timer_reload   (timer_reload),
		.channel_restart(channel_restart),
		.length_index   (length_index)
	);

	apu_sweep_timer_unit #(
		.negate_ones_complement(negate_ones_complement)
	) u_sweep_timer (
		.cpu_clk     (cpu_clk),
		.reset       (reset),
		.regs        (regs),
		.timer_reload(timer_reload),
		.sweep_reload(sweep_reload),
		.half_frame  (half_frame),
		.step_tick   (step_tick),
		.mute        (mute)
	);

	apu_pulse_envelope u_envelope (
		.cpu_clk        (cpu_clk),
		.reset          (reset),
		.regs           (regs),
		.channel_restart(channel_restart),
		.quarter_frame  (quarter_frame),
		.volume         (volume)
	);

	apu_pulse_sequencer u_sequencer (
		.cpu_clk        (cpu_clk),
		.reset          (reset),
		.regs           (regs),
		.channel_restart(channel_restart),
		.length_index   (length_index),
		.step_tick      (step_tick),
		.half_frame     (half_frame),
		.mute           (mute),
		.volume         (volume),
		.sample         (sample),
		.active         (active)
	);

endmodule

`default_nettype wire

//--- logic/apu_pulse_envelope.sv
/* Start flag is serviced on the next quarter frame after a restart.
   Volume output is combinational from stored state. */
`default_nettype none

module apu_pulse_envelope (
	input  wire logic                 cpu_clk,
	input  wire logic                 reset,
	input  wire apu_pkg::pulse_regs_t regs,
	input  wire logic                 channel_restart,
	input  wire logic                 quarter_frame,
	output logic [3:0]                volume
);

	logic       start_flag;
	logic [3:0] env_div;
	logic [3:0] decay;

	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			start_flag <= 1'b0;
			env_div    <= '0;
			decay      <= '0;
		end else begin
			if (quarter_frame) begin
				if (start_flag) begin
					start_flag <= 1'b0;
					decay      <= 4'd15;
					env_div    <= regs.ctrl.vol_period;
				end else if (env_div == 4'd0) begin
					env_div <= regs.ctrl.vol_period;
					if (decay != 4'd0)
						decay <= decay - 4'd1;
					else if (regs.ctrl.halt_loop)
						decay <= 4'd15;
				end else begin
					env_div <= env_div - 4'd1;
				end
			end
			// A restart in the same cycle waits for the next quarter frame
			if (channel_restart)
				start_flag <= 1'b1;
		end
	end

	assign volume = regs.ctrl.const_vol ? regs.ctrl.vol_period : decay;

endmodule

`default_nettype wire

//--- logic/apu_pulse_regs.sv
/* Writes are always accepted, one per cycle at most.
   Strobes go high for exactly one cycle, the cycle after the write. */
`default_nettype none

module apu_pulse_regs (
	input  wire logic              cpu_clk,
	input  wire logic              reset,
	input  wire logic              reg_write,
	input  wire logic [1:0]        reg_addr,
	input  wire apu_pkg::reg_data_u reg_data,
	output apu_pkg::pulse_regs_t   regs,
	output logic                   sweep_reload,
	output logic                   timer_reload,
	output logic                   channel_restart,
	output logic [4:0]             length_index
);

	//============================================================
	// Stored fields and strobes
	//============================================================
	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			regs            <= '0;
			sweep_reload    <= 1'b0;
			timer_reload    <= 1'b0;
			channel_restart <= 1'b0;
		end else begin
			sweep_reload    <= reg_write && (reg_addr == 2'd1);
			timer_reload    <= reg_write && reg_addr[1];
			channel_restart <= reg_write && (reg_addr == 2'd3);
			if (reg_write) begin
				case (reg_addr)
					2'd0: regs.ctrl <= reg_data.ctrl;
					2'd1: regs.sweep <= reg_data.sweep;
					2'd2: regs.timer[7:0] <= reg_data.raw;
					// Timer high bits share the byte with the length index
					2'd3: regs.timer[10:8] <= reg_data.raw[2:0];
				endcase
			end
		end
	end

	// Only meaningful alongside channel_restart
	always_ff @(posedge cpu_clk) begin
		if (reg_write && (reg_addr == 2'd3))
			length_index <= reg_data.raw[7:3];
	end

endmodule

`default_nettype wire

//--- logic/apu_pulse_sequencer.sv
/* Length loads on every restart, there is no channel enable register.
   Sample is registered, one cycle behind its inputs. */
`default_nettype none

module apu_pulse_sequencer (
	input  wire logic                 cpu_clk,
	input  wire logic                 reset,
	input  wire apu_pkg::pulse_regs_t regs,
	input  wire logic                 channel_restart,
	input  wire logic [4:0]           length_index,
	input  wire logic                 step_tick,
	input  wire logic                 half_frame,
	input  wire logic                 mute,
	input  wire logic [3:0]           volume,
	output logic [3:0]                sample,
	output logic                      active
);

	import apu_pkg::*;

	logic [2:0] step;
	logic [7:0] length_cnt;
	logic       duty_bit;

	// Leftmost pattern bit is step 0
	assign duty_bit = duty_table[regs.ctrl.duty][3'd7 - step];
	assign active = (length_cnt != 8'd0);

	//============================================================
	// Duty step and length counter
	//============================================================
	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			step       <= '0;
			length_cnt <= '0;
		end else begin
			if (channel_restart)
				step <= '0;
			else if (step_tick)
				step <= step + 3'd1;

			if (channel_restart)
				length_cnt <= length_table[length_index];
			else if (half_frame && active && !regs.ctrl.halt_loop)
				length_cnt <= length_cnt - 8'd1;
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (reset)
			sample <= '0;
		else
			sample <= (duty_bit && active && !mute) ? volume : 4'd0;
	end

endmodule

`default_nettype wire

//--- logic/apu_sweep_timer_unit.sv
/* Period changes from sweep land at the next timer wrap, writes restart the timer.
   negate_ones_complement = 1 gives pulse 1 behaviour, 0 gives pulse 2. */
`default_nettype none

module apu_sweep_timer_unit #(
	parameter bit negate_ones_complement = 1'b1
) (
	input  wire logic                 cpu_clk,
	input  wire logic                 reset,
	input  wire apu_pkg::pulse_regs_t regs,
	input  wire logic                 timer_reload,
	input  wire logic                 sweep_reload,
	input  wire logic                 half_frame,
	output logic                      step_tick,
	output logic                      mute
);

	import apu_pkg::*;

	logic [10:0] current_period;
	logic [10:0] change;
	logic [11:0] target;
	logic        target_over;
	logic        sweep_apply;
	logic [2:0]  sweep_div;
	logic        sweep_reload_pend;
	logic [10:0] timer_cnt;
	logic        timer_half;

	//============================================================
	// Sweep target and mute
	//============================================================
	always_comb begin
		change = current_period >> regs.sweep.shift;
		if (regs.sweep.negate)
			target = {1'b0, current_period} - {1'b0, change}
				- {11'd0, negate_ones_complement};
		else
			target = {1'b0, current_period} + {1'b0, change};
	end

	// Negate never pushes the target over the top
	assign target_over = !regs.sweep.negate && (target > {1'b0, period_max});
	assign mute = (current_period < 11'd8) || target_over;

	assign sweep_apply = half_frame && (sweep_div == 3'd0) && regs.sweep.enable
		&& (regs.sweep.shift != 3'd0) && !mute;

	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			current_period    <= '0;
			sweep_div         <= '0;
			sweep_reload_pend <= 1'b0;
		end else begin
			if (timer_reload)
				current_period <= regs.timer;
			else if (sweep_apply)
				current_period <= target[10:0];

			if (half_frame) begin
				if ((sweep_div == 3'd0) || sweep_reload_pend) begin
					sweep_div         <= regs.sweep.period;
					sweep_reload_pend <= 1'b0;
				end else begin
					sweep_div <= sweep_div - 3'd1;
				end
			end
			if (sweep_reload)
				sweep_reload_pend <= 1'b1;
		end
	end

	//============================================================
	// Timer, two wraps per sequencer step
	//============================================================
	always_ff @(posedge cpu_clk) begin
		if (reset) begin
			timer_cnt  <= '0;
			timer_half <= 1'b0;
			step_tick  <= 1'b0;
		end else begin
			step_tick <= (timer_cnt == 11'd0) && timer_half;
			if (timer_reload) begin
				timer_cnt  <= regs.timer;
				timer_half <= 1'b0;
			end else if (timer_cnt == 11'd0) begin
				timer_cnt  <= current_period;
				timer_half <= ~timer_half;
			end else begin
				timer_cnt <= timer_cnt - 11'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the pulse channel testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing -f apu_pulse.f --top-module apu_pulse_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vapu_pulse_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1
